// ==== verilog.f ====
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/rvc_expander.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_top.sv
dv/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
  -f verilog.f -Mdir obj_dir -o core_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

// ==== dv/core_tb.sv ====
`timescale 1ns/1ns

module core_tb;

  import isa_pkg::*;
  import core_pkg::*;

  localparam int IMEM_WORDS = 256;

  logic        clk;
  logic        rst;
  logic        start;
  logic        load_valid;
  logic [7:0]  load_addr;
  instr_t      load_data;
  logic        retire_valid;
  retire_t     retire_info;
  logic        halted;

  logic [15:0] hw [0:511];  // program image as halfwords.
  int          hw_len;
  logic [31:0] model_regs [0:31];
  retire_t     exp_q [$];
  logic [31:0] rng_state = 32'hc1e813bc;
  int          cycle_limit = 20;  // grows as each program is queued.
  int          cycle_count;
  int          err_count;
  int          check_count;
  int          test_count;
  int          err_mark;
  int          chk_mark;

  core_top #(.IMEM_WORDS(IMEM_WORDS)) UUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .load_valid   (load_valid),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire_info  (retire_info),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // encoders for the 32-bit and 16-bit formats.
  function automatic instr_t lui_word(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic instr_t addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, F3_ADD, rd, OP_IMM};
  endfunction

  function automatic instr_t rop_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic instr_t branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic instr_t jal_word(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [15:0] ci_half(logic [2:0] f3, logic [4:0] rd, logic [5:0] imm);
    return {f3, imm[5], rd, imm[4:0], 2'b01};  // f3 selects c.li (010) or c.addi (000).
  endfunction

  function automatic logic [15:0] cr_half(logic [3:0] f4, logic [4:0] rd, logic [4:0] rs2);
    return {f4, rd, rs2, 2'b10};  // f4 selects c.mv (1000) or c.add (1001).
  endfunction

  function automatic logic [15:0] cj_half(logic [11:0] off);
    return {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5],
            2'b01};
  endfunction

  function automatic logic [15:0] prog_half(int idx);
    return (idx < hw_len) ? hw[idx] : 16'hffff;  // past the end reads as halt.
  endfunction

  task automatic emit32(input instr_t w);
    hw[hw_len]     = w[15:0];
    hw[hw_len + 1] = w[31:16];
    hw_len += 2;
  endtask

  task automatic emit16(input logic [15:0] h);
    hw[hw_len] = h;
    hw_len += 1;
  endtask

  // lui plus addi with the upper part rounded for the signed low part.
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
    emit32(lui_word(rd, v[31:12] + {19'b0, v[11]}));
    emit32(addi_word(rd, rd, v[11:0]));
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_retire(input retire_t got, input retire_t exp);
    check_count++;
    if (got.pc !== exp.pc) begin
      err_count++;
      $display("[FAIL] retire_info.pc: got %h, expected %h", got.pc, exp.pc);
    end else if (got.wen !== exp.wen) begin
      err_count++;
      $display("[FAIL] retire_info.wen at pc %h: got %h, expected %h", exp.pc, got.wen, exp.wen);
    end else if (exp.wen && got.rd !== exp.rd) begin
      err_count++;
      $display("[FAIL] retire_info.rd at pc %h: got %h, expected %h", exp.pc, got.rd, exp.rd);
    end else if (exp.wen && got.value !== exp.value) begin
      err_count++;
      $display("[FAIL] retire_info.value at pc %h: got %h, expected %h",
               exp.pc, got.value, exp.value);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // ISA reference that walks the halfword image and builds the expected retire list.
  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [15:0] h;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] imm6;
    logic        wr;
    logic        done;
    retire_t     rec;
    int          steps;
    pc   = 32'd0;
    done = 1'b0;
    exp_q.delete();
    for (steps = 0; steps < 400 && !done; steps++) begin
      w = {prog_half(int'(pc[9:1]) + 1), prog_half(int'(pc[9:1]))};
      if (w == 32'hffff_ffff) begin
        done = 1'b1;
      end else begin
        wr      = 1'b0;
        res     = 32'd0;
        rd      = w[11:7];
        next_pc = pc + 32'd4;
        if (w[1:0] == 2'b11) begin
          a = model_regs[w[19:15]];
          b = model_regs[w[24:20]];
          case (w[6:0])
            OP_LUI: begin
              wr  = 1'b1;
              res = {w[31:12], 12'b0};
            end
            OP_IMM: begin
              wr  = (w[14:12] == F3_ADD);
              res = a + {{20{w[31]}}, w[31:20]};
            end
            OP_REG: begin
              wr = 1'b1;
              case ({w[31:25], w[14:12]})
                {F7_BASE, F3_ADD}: res = a + b;
                {F7_SUB, F3_ADD}:  res = a - b;
                {F7_BASE, F3_AND}: res = a & b;
                {F7_BASE, F3_OR}:  res = a | b;
                {F7_BASE, F3_XOR}: res = a ^ b;
                {F7_BASE, F3_SLT}: res = {31'b0, $signed(a) < $signed(b)};
                default:           wr = 1'b0;
              endcase
            end
            OP_BRANCH: begin
              if ((w[14:12] == F3_BEQ && a == b) || (w[14:12] == F3_BNE && a != b) ||
                  (w[14:12] == F3_BLT && $signed(a) < $signed(b))) begin
                next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
              end
            end
            OP_JAL: begin
              wr      = 1'b1;
              res     = pc + 32'd4;
              next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;
          endcase
        end else begin
          h       = w[15:0];
          next_pc = pc + 32'd2;
          a       = model_regs[h[11:7]];
          b       = model_regs[h[6:2]];
          imm6    = {{26{h[12]}}, h[12], h[6:2]};
          if (h[1:0] == 2'b01 && h[15:13] == 3'b010) begin
            wr  = 1'b1;  // c.li.
            res = imm6;
          end else if (h[1:0] == 2'b01 && h[15:13] == 3'b000) begin
            wr  = 1'b1;  // c.addi.
            res = a + imm6;
          end else if (h[1:0] == 2'b01 && h[15:13] == 3'b101) begin
            next_pc = pc + {{20{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11],
                            h[5:3], 1'b0};
          end else if (h[1:0] == 2'b10 && h[15:12] == 4'b1000 && h[6:2] != 5'd0) begin
            wr  = 1'b1;  // c.mv.
            res = b;
          end else if (h[1:0] == 2'b10 && h[15:12] == 4'b1001 && h[6:2] != 5'd0) begin
            wr  = 1'b1;  // c.add.
            res = a + b;
          end
        end
        rec.pc    = pc;
        rec.wen   = wr && (rd != 5'd0);
        rec.rd    = rec.wen ? rd : 5'd0;
        rec.value = rec.wen ? res : 32'd0;
        if (rec.wen) model_regs[rd] = res;
        exp_q.push_back(rec);
        pc = next_pc;
      end
    end
    if (!done) begin
      err_count++;
      $display("reference model ran 400 steps without reaching the halt word");
    end
  endtask

  task automatic load_program();
    int n_words;
    int i;
    n_words = (hw_len + 1) / 2 + 1;  // one spare halt word at the end.
    for (i = 0; i < n_words; i++) begin
      load_valid = 1'b1;
      load_addr  = 8'(i);
      load_data  = {prog_half(2 * i + 1), prog_half(2 * i)};
      tick();
    end
    load_valid = 1'b0;
  endtask

  task automatic run_program();
    int idx;
    run_model();
    cycle_limit += 4 * ((hw_len + 1) / 2 + 1 + exp_q.size()) + 50;
    load_program();
    start = 1'b1;
    idx   = 0;
    while (!(halted && idx >= exp_q.size())) begin
      tick();
      if (retire_valid) begin
        if (idx < exp_q.size()) begin
          compare_retire(retire_info, exp_q[idx]);
        end else begin
          err_count++;
          $display("unexpected extra retire at pc %h", retire_info.pc);
        end
        idx++;
      end
    end
    repeat (6) begin
      tick();
      compare_bit("halted", halted, 1'b1);  // pc holds on the halt word.
      if (retire_valid) begin
        err_count++;
        $display("instruction at pc %h retired after the core halted", retire_info.pc);
      end
    end
    start = 1'b0;
    tick();
    compare_bit("halted", halted, 1'b0);  // start low parks the core.
  endtask

  task automatic begin_test();
    hw_len   = 0;
    err_mark = err_count;
    chk_mark = check_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %s: %0d checks, %0d errors", name, check_count - chk_mark,
             err_count - err_mark);
  endtask

  task automatic test_alu();
    logic [31:0] r;
    int          k;
    begin_test();
    for (k = 1; k <= 8; k++) set_reg(5'(k), next_rand());
    r = next_rand();
    emit32(addi_word(5'd9, 5'd1, r[11:0]));
    emit32(lui_word(5'd10, r[31:12]));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd11, 5'd1, 5'd2));
    emit32(rop_word(F7_SUB, F3_ADD, 5'd12, 5'd3, 5'd4));
    emit32(rop_word(F7_BASE, F3_AND, 5'd13, 5'd5, 5'd6));
    emit32(rop_word(F7_BASE, F3_OR, 5'd14, 5'd7, 5'd8));
    emit32(rop_word(F7_BASE, F3_XOR, 5'd15, 5'd1, 5'd8));
    emit32(rop_word(F7_BASE, F3_SLT, 5'd16, 5'd1, 5'd2));
    emit32(rop_word(F7_BASE, F3_SLT, 5'd17, 5'd2, 5'd1));
    emit32(addi_word(5'd0, 5'd3, 12'd5));  // write to x0 is dropped.
    emit32(rop_word(F7_BASE, F3_ADD, 5'd18, 5'd0, 5'd0));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd19, 5'd0, 5'd3));
    for (k = 0; k < 10; k++) begin
      r = next_rand();
      case (r[2:0])
        3'd0:    emit32(rop_word(F7_BASE, F3_ADD, 5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15),
                                 5'(1 + r[15:12] % 15)));
        3'd1:    emit32(rop_word(F7_SUB, F3_ADD, 5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15),
                                 5'(1 + r[15:12] % 15)));
        3'd2:    emit32(rop_word(F7_BASE, F3_AND, 5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15),
                                 5'(1 + r[15:12] % 15)));
        3'd3:    emit32(rop_word(F7_BASE, F3_XOR, 5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15),
                                 5'(1 + r[15:12] % 15)));
        3'd4:    emit32(rop_word(F7_BASE, F3_SLT, 5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15),
                                 5'(1 + r[15:12] % 15)));
        default: emit32(addi_word(5'(1 + r[7:4] % 15), 5'(1 + r[11:8] % 15), r[31:20]));
      endcase
    end
    emit32(HALT_WORD);
    run_program();
    end_test("alu");
  endtask

  task automatic test_dependences();
    begin_test();
    emit32(addi_word(5'd1, 5'd0, 12'd7));
    emit32(addi_word(5'd1, 5'd1, 12'd3));  // reads the result still in execute.
    emit32(rop_word(F7_BASE, F3_ADD, 5'd2, 5'd1, 5'd1));
    emit32(rop_word(F7_SUB, F3_ADD, 5'd3, 5'd2, 5'd1));
    emit32(addi_word(5'd4, 5'd0, 12'd100));
    emit32(addi_word(5'd5, 5'd0, 12'(-1)));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd6, 5'd4, 5'd3));  // x4 through the write-through.
    emit32(rop_word(F7_BASE, F3_ADD, 5'd6, 5'd6, 5'd6));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd6, 5'd6, 5'd5));
    emit32(addi_word(5'd0, 5'd1, 12'd1));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd7, 5'd0, 5'd1));
    emit32(rop_word(F7_BASE, F3_XOR, 5'd8, 5'd7, 5'd6));
    emit32(HALT_WORD);
    run_program();
    end_test("dependences");
  endtask

  task automatic test_branches();
    begin_test();
    emit32(addi_word(5'd1, 5'd0, 12'd5));                 // 0
    emit32(addi_word(5'd2, 5'd0, 12'd5));                 // 4
    emit32(addi_word(5'd3, 5'd0, 12'(-3)));               // 8
    emit32(addi_word(5'd4, 5'd0, 12'd9));                 // 12
    emit32(branch_word(F3_BNE, 5'd1, 5'd4, 13'd12));      // 16 branches to 28.
    emit32(addi_word(5'd10, 5'd0, 12'd1));                // 20
    emit32(addi_word(5'd11, 5'd0, 12'd2));                // 24
    emit32(branch_word(F3_BEQ, 5'd1, 5'd2, 13'd8));       // 28 branches to 36.
    emit32(addi_word(5'd12, 5'd0, 12'd3));                // 32
    emit32(branch_word(F3_BEQ, 5'd1, 5'd4, 13'd8));       // 36
    emit32(addi_word(5'd13, 5'd0, 12'd4));                // 40
    emit32(branch_word(F3_BNE, 5'd1, 5'd2, 13'd8));       // 44
    emit32(addi_word(5'd14, 5'd0, 12'd5));                // 48
    emit32(branch_word(F3_BLT, 5'd3, 5'd1, 13'd8));       // 52 compares signed.
    emit32(addi_word(5'd15, 5'd0, 12'd6));                // 56
    emit32(branch_word(F3_BLT, 5'd1, 5'd3, 13'd8));       // 60
    emit32(branch_word(F3_BLT, 5'd4, 5'd4, 13'd8));       // 64
    emit32(jal_word(5'd5, 21'd8));                        // 68 links 72.
    emit32(addi_word(5'd16, 5'd0, 12'd7));                // 72
    emit32(rop_word(F7_BASE, F3_ADD, 5'd17, 5'd5, 5'd0)); // 76
    emit32(HALT_WORD);
    run_program();
    end_test("branches");
  endtask

  task automatic test_compressed();
    begin_test();
    emit16(ci_half(3'b010, 5'd8, 6'(-5)));                // 0 c.li
    emit32(addi_word(5'd9, 5'd8, 12'd100));               // 2 spans two words.
    emit16(cr_half(4'b1000, 5'd10, 5'd9));                // 6 c.mv
    emit16(cr_half(4'b1001, 5'd10, 5'd8));                // 8 c.add
    emit16(cj_half(12'd6));                               // 10 lands on 16.
    emit16(ci_half(3'b010, 5'd11, 6'd1));                 // 12
    emit16(ci_half(3'b010, 5'd12, 6'd2));                 // 14
    emit32(rop_word(F7_BASE, F3_ADD, 5'd13, 5'd10, 5'd9)); // 16
    emit16(ci_half(3'b000, 5'd13, 6'(-1)));               // 20 c.addi
    emit16(16'h0040);                                     // 22 in quadrant 0 is a no-op.
    emit32(lui_word(5'd14, 20'h12345));                   // 24
    emit16(cj_half(12'd4));                               // 28
    emit16(ci_half(3'b010, 5'd12, 6'd3));                 // 30
    emit16(ci_half(3'b000, 5'd14, 6'd5));                 // 32
    emit32(HALT_WORD);                                    // 34 at an odd halfword.
    run_program();
    end_test("compressed");
  endtask

  task automatic test_halt_restart();
    begin_test();
    emit32(addi_word(5'd1, 5'd0, 12'd11));
    emit32(addi_word(5'd2, 5'd0, 12'd22));
    emit32(HALT_WORD);
    emit32(addi_word(5'd3, 5'd0, 12'd33));  // beyond the halt and never runs.
    run_program();
    hw_len = 0;
    emit32(addi_word(5'd3, 5'd0, 12'd44));
    emit32(rop_word(F7_BASE, F3_ADD, 5'd4, 5'd3, 5'd1));
    emit16(ci_half(3'b010, 5'd5, 6'd9));
    emit32(HALT_WORD);
    run_program();
    end_test("halt_restart");
  endtask

  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not complete", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    load_valid  = 1'b0;
    load_addr   = 8'd0;
    load_data   = 32'd0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    for (int k = 0; k < 32; k++) model_regs[k] = 32'd0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    tick();
    test_alu();
    test_dependences();
    test_branches();
    test_compressed();
    test_halt_restart();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/1ns

module core_top #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          load_valid,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  isa_pkg::instr_t               load_data,
  output logic                          retire_valid,
  output core_pkg::retire_t             retire_info,
  output logic                          halted
);

  import core_pkg::*;

  fd_t         fd;
  dx_t         dx;
  xr_t         xr;
  logic [4:0]  rs1_addr, rs2_addr;
  logic [31:0] rs1_data, rs2_data;
  logic        stall;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .load_valid     (load_valid),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .halted         (halted),
    .fd             (fd)
  );

  decode_stage u_decode (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .fd             (fd),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .ex_rd          (dx.rd),   // hazard check against execute.
    .ex_wen         (dx.wen),
    .redirect_valid (redirect_valid),
    .stall          (stall),
    .dx             (dx)
  );

  execute_stage u_execute (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .dx             (dx),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .xr             (xr)
  );

  result_stage u_result (
    .clk          (clk),
    .rst          (rst),
    .xr           (xr),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire_info  (retire_info)
  );

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ns

module result_stage (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::xr_t     xr,
  input  logic [4:0]        rs1_addr,
  input  logic [4:0]        rs2_addr,
  output logic [31:0]       rs1_data,
  output logic [31:0]       rs2_data,
  output logic              retire_valid,
  output core_pkg::retire_t retire_info
);

  logic [31:0] rf [1:31];  // x0 is not stored.
  logic        wr_en;

  assign wr_en = xr.valid && xr.wen && (xr.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      rf[xr.rd] <= xr.value;
    end
  end

  // write-through so decode sees the value retiring this cycle.
  assign rs1_data = (rs1_addr == 5'd0)              ? 32'd0 :
                    (wr_en && rs1_addr == xr.rd)    ? xr.value :
                                                      rf[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0)              ? 32'd0 :
                    (wr_en && rs2_addr == xr.rd)    ? xr.value :
                                                      rf[rs2_addr];

  assign retire_valid = xr.valid;
  assign retire_info  = '{pc: xr.pc, rd: xr.rd, value: xr.value, wen: xr.wen};

  // decode masks x0 writes, so none should reach here.
  a_no_x0_write : assert property (@(posedge clk) disable iff (rst)
    xr.valid && xr.wen |-> xr.rd != 5'd0)
    else $error("write enable set for x0.");

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  core_pkg::dx_t dx,
  output logic          redirect_valid,
  output logic [31:0]   redirect_pc,
  output core_pkg::xr_t xr
);

  import core_pkg::*;

  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic [31:0] link;
  logic        taken;

  assign op_b = dx.uses_imm ? dx.imm : dx.rs2_val;

  always_comb begin
    case (dx.alu_op)
      ALU_ADD:    alu_out = dx.rs1_val + op_b;
      ALU_SUB:    alu_out = dx.rs1_val - op_b;
      ALU_AND:    alu_out = dx.rs1_val & op_b;
      ALU_OR:     alu_out = dx.rs1_val | op_b;
      ALU_XOR:    alu_out = dx.rs1_val ^ op_b;
      ALU_SLT:    alu_out = {31'b0, $signed(dx.rs1_val) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  always_comb begin
    case (dx.br_kind)
      BR_BEQ:  taken = (dx.rs1_val == dx.rs2_val);
      BR_BNE:  taken = (dx.rs1_val != dx.rs2_val);
      BR_BLT:  taken = ($signed(dx.rs1_val) < $signed(dx.rs2_val));
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_valid = dx.valid && taken;
  assign redirect_pc    = dx.pc + dx.imm;  // b and j offsets are pc relative.

  assign link = dx.pc + (dx.compressed ? 32'd2 : 32'd4);  // c.j links past 2 bytes.

  always_ff @(posedge clk) begin
    if (rst || !start) begin
      xr.valid <= 1'b0;
    end else begin
      xr.valid <= dx.valid;
      xr.pc    <= dx.pc;
      xr.rd    <= dx.rd;
      xr.value <= (dx.br_kind == BR_JUMP) ? link : alu_out;
      xr.wen   <= dx.wen;
    end
  end

  // decode flushes behind a redirect, so the strobe lasts one cycle.
  a_redirect_strobe : assert property (@(posedge clk) disable iff (rst || !start)
    redirect_valid |-> dx.valid ##1 !redirect_valid)
    else $error("redirect without a valid branch, or held too long.");

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  core_pkg::fd_t fd,
  output logic [4:0]    rs1_addr,
  output logic [4:0]    rs2_addr,
  input  logic [31:0]   rs1_data,
  input  logic [31:0]   rs2_data,
  input  logic [4:0]    ex_rd,
  input  logic          ex_wen,
  input  logic          redirect_valid,
  output logic          stall,
  output core_pkg::dx_t dx
);

  import isa_pkg::*;
  import core_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [31:0] imm_i, imm_u, imm_b, imm_j;

  logic [31:0] dec_imm;
  logic        dec_uses_imm;
  logic        dec_wen;
  logic        uses_rs1;
  logic        uses_rs2;
  alu_op_e     dec_alu;
  br_kind_e    dec_br;

  assign opcode   = fd.instr[6:0];
  assign rd       = fd.instr[11:7];
  assign funct3   = fd.instr[14:12];
  assign rs1_addr = fd.instr[19:15];
  assign rs2_addr = fd.instr[24:20];
  assign funct7   = fd.instr[31:25];

  assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
  assign imm_u = {fd.instr[31:12], 12'b0};
  assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                  fd.instr[11:8], 1'b0};
  assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                  fd.instr[30:21], 1'b0};

  always_comb begin
    // anything unmatched falls out as a no-op.
    dec_imm      = '0;
    dec_uses_imm = 1'b0;
    dec_wen      = 1'b0;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    dec_alu      = ALU_ADD;
    dec_br       = BR_NONE;
    case (opcode)
      OP_LUI: begin
        dec_imm      = imm_u;
        dec_uses_imm = 1'b1;
        dec_alu      = ALU_PASS_B;
        dec_wen      = 1'b1;
      end
      OP_IMM: begin
        dec_imm      = imm_i;
        dec_uses_imm = 1'b1;
        dec_wen      = (funct3 == F3_ADD);  // addi only.
        uses_rs1     = dec_wen;
      end
      OP_REG: begin
        dec_wen = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD}: dec_alu = ALU_ADD;
          {F7_SUB, F3_ADD}:  dec_alu = ALU_SUB;
          {F7_BASE, F3_AND}: dec_alu = ALU_AND;
          {F7_BASE, F3_OR}:  dec_alu = ALU_OR;
          {F7_BASE, F3_XOR}: dec_alu = ALU_XOR;
          {F7_BASE, F3_SLT}: dec_alu = ALU_SLT;
          default:           dec_wen = 1'b0;
        endcase
        uses_rs1 = dec_wen;
        uses_rs2 = dec_wen;
      end
      OP_BRANCH: begin
        dec_imm = imm_b;
        case (funct3)
          F3_BEQ:  dec_br = BR_BEQ;
          F3_BNE:  dec_br = BR_BNE;
          F3_BLT:  dec_br = BR_BLT;
          default: dec_br = BR_NONE;
        endcase
        uses_rs1 = (dec_br != BR_NONE);
        uses_rs2 = (dec_br != BR_NONE);
      end
      OP_JAL: begin
        dec_imm = imm_j;
        dec_br  = BR_JUMP;
        dec_wen = 1'b1;
      end
      default: ;
    endcase
  end

  // without forwarding from execute the reader waits one cycle for the write-through.
  assign stall = fd.valid && ex_wen && (ex_rd != 5'd0) &&
                 ((uses_rs1 && rs1_addr == ex_rd) || (uses_rs2 && rs2_addr == ex_rd));

  always_ff @(posedge clk) begin
    if (rst || !start || redirect_valid || stall) begin
      dx.valid <= 1'b0;  // bubble.
      dx.wen   <= 1'b0;  // ex_wen is fed back from here.
    end else begin
      dx <= '{valid: fd.valid, pc: fd.pc, compressed: fd.compressed,
              rs1_val: rs1_data, rs2_val: rs2_data, imm: dec_imm,
              uses_imm: dec_uses_imm, alu_op: dec_alu, br_kind: dec_br,
              rd: rd, wen: fd.valid && dec_wen && (rd != 5'd0)};
    end
  end

  // both younger instructions are dropped behind a taken branch.
  a_flush_kills : assert property (@(posedge clk) disable iff (rst)
    redirect_valid |=> !dx.valid && !fd.valid)
    else $error("instruction survived a redirect.");

  // fetch must keep the stalled instruction for the retry.
  a_stall_holds : assert property (@(posedge clk) disable iff (rst || !start)
    stall && !redirect_valid |=> fd == $past(fd))
    else $error("fetch moved during a decode stall.");

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          load_valid,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  isa_pkg::instr_t               load_data,
  input  logic                          stall,
  input  logic                          redirect_valid,
  input  logic [31:0]                   redirect_pc,
  output logic                          halted,
  output core_pkg::fd_t                 fd
);

  import isa_pkg::*;

  localparam int WA = $clog2(IMEM_WORDS);

  // one bank per halfword lane, so a word at any halfword spans both.
  logic [15:0] mem_lo [IMEM_WORDS];
  logic [15:0] mem_hi [IMEM_WORDS];

  logic [31:0]   pc;
  logic [WA-1:0] word_idx;
  logic [WA-1:0] word_next;
  instr_t        raw;
  instr_t        expanded;
  logic          is_compressed;

  always_ff @(posedge clk) begin
    if (!start && load_valid) begin
      mem_lo[load_addr] <= load_data[15:0];
      mem_hi[load_addr] <= load_data[31:16];
    end
  end

  assign word_idx  = pc[WA+1:2];
  assign word_next = word_idx + 1'b1;

  // at an odd halfword the upper half comes from the next word.
  assign raw = pc[1] ? {mem_lo[word_next], mem_hi[word_idx]}
                     : {mem_hi[word_idx], mem_lo[word_idx]};
  assign is_compressed = (raw[1:0] != 2'b11);

  rvc_expander u_expander (
    .instr_in  (raw),
    .instr_out (expanded)
  );

  always_ff @(posedge clk) begin
    if (rst || !start) begin  // idle core parks at address zero.
      pc       <= '0;
      fd.valid <= 1'b0;
      halted   <= 1'b0;
    end else if (redirect_valid) begin
      pc       <= redirect_pc;
      fd.valid <= 1'b0;
      halted   <= 1'b0;  // halt word may have been on the wrong path.
    end else if (!stall) begin
      if (raw == HALT_WORD) begin
        fd.valid <= 1'b0;
        halted   <= 1'b1;
      end else begin
        pc <= pc + (is_compressed ? 32'd2 : 32'd4);
        fd <= '{valid: 1'b1, pc: pc, instr: expanded, compressed: is_compressed};
      end
    end
  end

  a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
    else $error("pc lost halfword alignment.");

endmodule

// ==== hdl/rvc_expander.sv ====
`timescale 1ns/1ns

module rvc_expander (
  input  isa_pkg::instr_t instr_in,
  output isa_pkg::instr_t instr_out
);

  import isa_pkg::*;

  logic [1:0]  quad;
  logic [2:0]  funct3;
  logic [3:0]  funct4;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] ci_imm;
  logic [20:0] cj_imm;

  assign quad   = instr_in[1:0];
  assign funct3 = instr_in[15:13];
  assign funct4 = instr_in[15:12];
  assign rd     = instr_in[11:7];
  assign rs2    = instr_in[6:2];

  // 6-bit signed immediate of the ci format.
  assign ci_imm = {{6{instr_in[12]}}, instr_in[12], instr_in[6:2]};

  // c.j scatters offset[11:1] over bits 12..2.
  assign cj_imm = {{9{instr_in[12]}}, instr_in[12], instr_in[8], instr_in[10:9],
                   instr_in[6], instr_in[7], instr_in[2], instr_in[11],
                   instr_in[5:3], 1'b0};

  always_comb begin
    instr_out = NOP_WORD;  // unsupported compressed forms.
    if (quad == 2'b11) begin
      instr_out = instr_in;
    end else if (quad == C_Q1) begin
      case (funct3)
        C_F3_LI:   instr_out = enc_addi(rd, 5'd0, ci_imm);
        C_F3_ADDI: instr_out = enc_addi(rd, rd, ci_imm);
        C_F3_J:    instr_out = enc_jal(5'd0, cj_imm);
        default:   instr_out = NOP_WORD;
      endcase
    end else if (quad == C_Q2) begin
      // rs2 of zero selects c.jr / c.jalr / c.ebreak instead.
      if (funct4 == C_F4_MV && rs2 != 5'd0) begin
        instr_out = enc_add(rd, 5'd0, rs2);
      end else if (funct4 == C_F4_ADD && rs2 != 5'd0) begin
        instr_out = enc_add(rd, rd, rs2);
      end
    end
  end

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // lui result is the immediate.
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_JUMP
  } br_kind_e;

  typedef struct packed {
    logic           valid;
    logic [31:0]    pc;
    isa_pkg::instr_t instr;      // already expanded.
    logic           compressed;
  } fd_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        compressed;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic        uses_imm;
    alu_op_e     alu_op;
    br_kind_e    br_kind;
    logic [4:0]  rd;
    logic        wen;     // never set for x0.
  } dx_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        wen;
  } xr_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        wen;
  } retire_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] instr_t;

  // major opcodes of the supported 32-bit instructions.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;  // also SUB and ADDI.
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // compressed quadrants and function fields.
  localparam logic [1:0] C_Q1       = 2'b01;
  localparam logic [1:0] C_Q2       = 2'b10;
  localparam logic [2:0] C_F3_ADDI  = 3'b000;
  localparam logic [2:0] C_F3_LI    = 3'b010;
  localparam logic [2:0] C_F3_J     = 3'b101;
  localparam logic [3:0] C_F4_MV    = 4'b1000;
  localparam logic [3:0] C_F4_ADD   = 4'b1001;

  localparam instr_t HALT_WORD = 32'hffff_ffff;  // stops fetch.
  localparam instr_t NOP_WORD  = 32'h0000_0013;  // addi x0, x0, 0.

  function automatic instr_t enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, F3_ADD, rd, OP_IMM};
  endfunction

  function automatic instr_t enc_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {F7_BASE, rs2, rs1, F3_ADD, rd, OP_REG};
  endfunction

  // imm is the byte offset, bit 0 is dropped by the format.
  function automatic instr_t enc_jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

endpackage
